// ==== hdl/cache_pkg.sv ====
package cache_pkg;

	localparam int word_bits = 32;
	localparam int strb_bits = 4;
	localparam int block_words = 2;
	localparam int cache_bytes = 1024;
	localparam int offset_bits = $clog2(block_words * strb_bits);
	localparam int num_lines = cache_bytes / (block_words * strb_bits);
	localparam int index_bits = $clog2(num_lines);
	localparam int tag_bits = word_bits - index_bits - offset_bits;
	localparam int word_sel_bits = $clog2(block_words);
	localparam int lane_bits = $clog2(strb_bits);

	// backing memory
	localparam int mem_words = 4096;
	localparam int read_delay = 10;
	localparam int write_delay = 15;
	localparam logic [word_bits-1:0] io_base = 32'h1000_0000;
	localparam logic [word_bits-1:0] display_addr = io_base;

	typedef logic [word_bits-1:0] addr_t;
	typedef logic [word_bits-1:0] word_t;
	typedef logic [strb_bits-1:0] strb_t;
	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [index_bits-1:0] index_t;
	typedef logic [word_sel_bits-1:0] word_sel_t;
	typedef logic [block_words*word_bits-1:0] line_data_t;

	// zero wstrb is a read
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		strb_t wstrb;
	} mem_req_t;

	typedef enum logic [2:0] {
		idle,
		lookup,
		read_hit,
		write_hit,
		write_back,
		fill,
		bypass
	} cache_state_t;

	function automatic tag_t addr_tag(addr_t addr);
		return addr[word_bits-1 -: tag_bits];
	endfunction

	function automatic index_t addr_index(addr_t addr);
		return addr[offset_bits +: index_bits];
	endfunction

	function automatic word_sel_t addr_word(addr_t addr);
		return addr[lane_bits +: word_sel_bits];
	endfunction

endpackage

// ==== hdl/cache_array.sv ====
`timescale 1ns/10ps

module cache_array (
	input  logic                   clk,
	input  logic                   resetn,
	input  cache_pkg::index_t      rd_index,
	output cache_pkg::tag_t        rd_tag,
	output cache_pkg::line_data_t  rd_data,
	output logic                   rd_valid,
	output logic                   rd_dirty,
	input  logic                   wr_en,
	input  cache_pkg::index_t      wr_index,
	input  cache_pkg::tag_t        wr_tag,
	input  cache_pkg::word_sel_t   wr_word,
	input  cache_pkg::word_t       wr_data,
	input  cache_pkg::strb_t       wr_strb,
	input  logic                   wr_fill
);
	import cache_pkg::*;

	tag_t tag_mem [num_lines];
	word_t data_mem [num_lines][block_words];
	logic [num_lines-1:0] valid_bits;
	logic [num_lines-1:0] dirty_bits;

	// tag and data storage with byte lane writes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < strb_bits; b++) begin
				if (wr_strb[b]) begin
					data_mem[wr_index][wr_word][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
			if (wr_fill) begin
				tag_mem[wr_index] <= wr_tag;
			end
		end
		rd_tag <= tag_mem[rd_index];
		for (int w = 0; w < block_words; w++) begin
			rd_data[w*word_bits +: word_bits] <= data_mem[rd_index][w];
		end
	end

	// a fill makes a clean line and a store makes it dirty
	always_ff @(posedge clk) begin
		if (!resetn) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			rd_valid <= 1'b0;
			rd_dirty <= 1'b0;
		end else begin
			if (wr_en) begin
				if (wr_fill) begin
					valid_bits[wr_index] <= 1'b1;
					dirty_bits[wr_index] <= 1'b0;
				end else begin
					dirty_bits[wr_index] <= 1'b1;
				end
			end
			rd_valid <= valid_bits[rd_index];
			rd_dirty <= dirty_bits[rd_index];
		end
	end

endmodule

// ==== hdl/cache_controller.sv ====
`timescale 1ns/10ps

module cache_controller (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   cpu_valid,
	input  cache_pkg::mem_req_t    cpu_req,
	output logic                   cpu_ready,
	output cache_pkg::word_t       cpu_rdata,
	output logic                   mem_valid,
	output cache_pkg::mem_req_t    mem_req,
	input  logic                   mem_ready,
	input  cache_pkg::word_t       mem_rdata,
	output cache_pkg::index_t      rd_index,
	input  cache_pkg::tag_t        rd_tag,
	input  cache_pkg::line_data_t  rd_data,
	input  logic                   rd_valid,
	input  logic                   rd_dirty,
	output logic                   wr_en,
	output cache_pkg::index_t      wr_index,
	output cache_pkg::tag_t        wr_tag,
	output cache_pkg::word_sel_t   wr_word,
	output cache_pkg::word_t       wr_data,
	output cache_pkg::strb_t       wr_strb,
	output logic                   wr_fill
);
	import cache_pkg::*;

	cache_state_t state;
	word_sel_t word_cnt;
	tag_t req_tag;
	index_t req_index;
	word_sel_t req_word;
	logic line_hit;
	logic last_word;
	word_t hit_word;
	word_t victim_word;

	assign req_tag = addr_tag(cpu_req.addr);
	assign req_index = addr_index(cpu_req.addr);
	assign req_word = addr_word(cpu_req.addr);
	assign line_hit = rd_valid && (rd_tag == req_tag);
	assign last_word = (word_cnt == word_sel_t'(block_words - 1));
	assign hit_word = rd_data[req_word*word_bits +: word_bits];
	assign victim_word = rd_data[word_cnt*word_bits +: word_bits];

	// the request stays stable so the line read follows it directly
	assign rd_index = req_index;
	assign wr_index = req_index;
	assign wr_tag = req_tag;

	// store on a hit or one fill word as it arrives
	always_comb begin
		wr_en = 1'b0;
		wr_fill = 1'b0;
		wr_word = req_word;
		wr_data = cpu_req.wdata;
		wr_strb = cpu_req.wstrb;
		if (state == write_hit) begin
			wr_en = 1'b1;
		end else if (state == fill) begin
			wr_fill = 1'b1;
			wr_en = mem_valid && mem_ready;
			wr_word = word_cnt;
			wr_data = mem_rdata;
			wr_strb = '1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= idle;
			cpu_ready <= 1'b0;
			mem_valid <= 1'b0;
			word_cnt <= '0;
		end else begin
			cpu_ready <= 1'b0;
			case (state)
				idle: begin
					if (cpu_valid && !cpu_ready) begin
						if (cpu_req.addr >= io_base) begin
							mem_valid <= 1'b1;
							mem_req <= cpu_req;
							state <= bypass;
						end else begin
							state <= lookup;
						end
					end
				end
				lookup: begin
					if (line_hit) begin
						state <= (|cpu_req.wstrb) ? write_hit : read_hit;
					end else if (rd_valid && rd_dirty) begin
						state <= write_back;
					end else begin
						state <= fill;
					end
				end
				read_hit: begin
					cpu_ready <= 1'b1;
					cpu_rdata <= hit_word;
					state <= idle;
				end
				write_hit: begin
					cpu_ready <= 1'b1;
					state <= idle;
				end
				// victim goes back to its own address starting at word 0
				write_back: begin
					if (!mem_valid) begin
						mem_valid <= 1'b1;
						mem_req.addr <= {rd_tag, req_index, word_cnt, {lane_bits{1'b0}}};
						mem_req.wdata <= victim_word;
						mem_req.wstrb <= '1;
					end else if (mem_ready) begin
						mem_valid <= 1'b0;
						word_cnt <= word_cnt + 1'b1;
						if (last_word) begin
							state <= fill;
						end
					end
				end
				fill: begin
					if (!mem_valid) begin
						mem_valid <= 1'b1;
						mem_req.addr <= {req_tag, req_index, word_cnt, {lane_bits{1'b0}}};
						mem_req.wdata <= '0;
						mem_req.wstrb <= '0;
					end else if (mem_ready) begin
						mem_valid <= 1'b0;
						word_cnt <= word_cnt + 1'b1;
						// idle gives the array a cycle before the retry
						if (last_word) begin
							state <= idle;
						end
					end
				end
				bypass: begin
					if (mem_ready) begin
						mem_valid <= 1'b0;
						cpu_ready <= 1'b1;
						cpu_rdata <= mem_rdata;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

// ==== hdl/backing_memory.sv ====
`timescale 1ns/10ps

module backing_memory (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 mem_valid,
	input  cache_pkg::mem_req_t  mem_req,
	output logic                 mem_ready,
	output cache_pkg::word_t     mem_rdata,
	output cache_pkg::word_t     display_value,
	output logic                 display_strobe
);
	import cache_pkg::*;

	word_t ram [mem_words] = '{default: '0};
	logic [$clog2(mem_words)-1:0] word_addr;
	logic [$clog2(write_delay + 1)-1:0] delay_cnt;
	logic [$clog2(write_delay + 1)-1:0] delay_last;
	logic is_write;
	logic is_display;

	assign word_addr = mem_req.addr[lane_bits +: $clog2(mem_words)];
	assign is_write = |mem_req.wstrb;
	assign is_display = (mem_req.addr == display_addr);
	assign delay_last = is_write ? $bits(delay_cnt)'(write_delay - 1) :
		$bits(delay_cnt)'(read_delay - 1);

	// the access itself happens on the cycle before ready
	always_ff @(posedge clk) begin
		if (!resetn) begin
			mem_ready <= 1'b0;
			delay_cnt <= '0;
			display_value <= '0;
			display_strobe <= 1'b0;
		end else begin
			mem_ready <= 1'b0;
			display_strobe <= 1'b0;
			if (mem_valid && !mem_ready) begin
				if (delay_cnt == delay_last) begin
					delay_cnt <= '0;
					mem_ready <= 1'b1;
					if (is_write && is_display) begin
						display_value <= mem_req.wdata;
						display_strobe <= 1'b1;
					end else if (!is_write) begin
						mem_rdata <= is_display ? display_value : ram[word_addr];
					end
				end else begin
					delay_cnt <= delay_cnt + 1'b1;
				end
			end
		end
	end

	// byte lanes of the word array
	always_ff @(posedge clk) begin
		if (resetn && mem_valid && !mem_ready && is_write && !is_display &&
				delay_cnt == delay_last) begin
			for (int b = 0; b < strb_bits; b++) begin
				if (mem_req.wstrb[b]) begin
					ram[word_addr][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== hdl/cached_memory_system.sv ====
`timescale 1ns/10ps

module cached_memory_system (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 cpu_valid,
	input  cache_pkg::mem_req_t  cpu_req,
	output logic                 cpu_ready,
	output cache_pkg::word_t     cpu_rdata,
	output cache_pkg::word_t     display_value,
	output logic                 display_strobe
);
	import cache_pkg::*;

	logic mem_valid;
	mem_req_t mem_req;
	logic mem_ready;
	word_t mem_rdata;

	// array ports
	index_t rd_index;
	tag_t rd_tag;
	line_data_t rd_data;
	logic rd_valid;
	logic rd_dirty;
	logic wr_en;
	index_t wr_index;
	tag_t wr_tag;
	word_sel_t wr_word;
	word_t wr_data;
	strb_t wr_strb;
	logic wr_fill;

	cache_controller cache_controller_inst (
		.clk       (clk),
		.resetn    (resetn),
		.cpu_valid (cpu_valid),
		.cpu_req   (cpu_req),
		.cpu_ready (cpu_ready),
		.cpu_rdata (cpu_rdata),
		.mem_valid (mem_valid),
		.mem_req   (mem_req),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.rd_index  (rd_index),
		.rd_tag    (rd_tag),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.rd_dirty  (rd_dirty),
		.wr_en     (wr_en),
		.wr_index  (wr_index),
		.wr_tag    (wr_tag),
		.wr_word   (wr_word),
		.wr_data   (wr_data),
		.wr_strb   (wr_strb),
		.wr_fill   (wr_fill)
	);

	cache_array cache_array_inst (
		.clk      (clk),
		.resetn   (resetn),
		.rd_index (rd_index),
		.rd_tag   (rd_tag),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.rd_dirty (rd_dirty),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_tag   (wr_tag),
		.wr_word  (wr_word),
		.wr_data  (wr_data),
		.wr_strb  (wr_strb),
		.wr_fill  (wr_fill)
	);

	backing_memory backing_memory_inst (
		.clk            (clk),
		.resetn         (resetn),
		.mem_valid      (mem_valid),
		.mem_req        (mem_req),
		.mem_ready      (mem_ready),
		.mem_rdata      (mem_rdata),
		.display_value  (display_value),
		.display_strobe (display_strobe)
	);

endmodule

// ==== tb/cache_checker.sv ====
`timescale 1ns/10ps

module cache_checker (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 cpu_valid,
	input  logic                 cpu_ready,
	input  logic                 mem_valid,
	input  cache_pkg::mem_req_t  mem_req,
	input  logic                 mem_ready
);
	int fail_count = 0;

	ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
		cpu_ready |-> cpu_valid)
	else begin
		fail_count++;
		$error("cpu_ready raised while cpu_valid is low");
	end

	// request held until the memory answers
	mem_request_held: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
	else begin
		fail_count++;
		$error("mem_valid or mem_req changed before mem_ready");
	end

	ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		cpu_ready |=> !cpu_ready)
	else begin
		fail_count++;
		$error("cpu_ready high for two cycles");
	end

	quiet_after_reset: assert property (@(posedge clk)
		$rose(resetn) |-> !cpu_ready && !mem_valid)
	else begin
		fail_count++;
		$error("cpu_ready or mem_valid high in the first cycle after reset");
	end

endmodule

bind cache_controller cache_checker cache_checker_inst (
	.clk       (clk),
	.resetn    (resetn),
	.cpu_valid (cpu_valid),
	.cpu_ready (cpu_ready),
	.mem_valid (mem_valid),
	.mem_req   (mem_req),
	.mem_ready (mem_ready)
);

// ==== tb/cache_monitor.sv ====
`timescale 1ns/10ps

module cache_monitor (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 cpu_valid,
	input  cache_pkg::mem_req_t  cpu_req,
	input  logic                 cpu_ready,
	input  cache_pkg::word_t     cpu_rdata,
	input  cache_pkg::word_t     display_value,
	input  logic                 display_strobe,
	output int                   error_count,
	output int                   strobe_count
);
	import cache_pkg::*;

	// byte image of the cached window that starts at zero like the backing memory
	logic [7:0] shadow [mem_words*strb_bits] = '{default: '0};
	word_t last_display = '0;
	int errors = 0;
	int strobes = 0;

	assign error_count = errors;
	assign strobe_count = strobes;

	function automatic int byte_index(addr_t addr, int lane);
		return int'({addr[13:2], 2'b00}) + lane;
	endfunction

	function automatic word_t expected_read(addr_t addr);
		word_t value;
		if (addr == display_addr) begin
			return last_display;
		end
		for (int b = 0; b < strb_bits; b++) begin
			value[b*8 +: 8] = shadow[byte_index(addr, b)];
		end
		return value;
	endfunction

	always @(posedge clk) begin
		word_t expected;
		if (resetn && cpu_valid && cpu_ready) begin
			if (|cpu_req.wstrb) begin
				if (cpu_req.addr == display_addr) begin
					last_display = cpu_req.wdata;
				end else begin
					for (int b = 0; b < strb_bits; b++) begin
						if (cpu_req.wstrb[b]) begin
							shadow[byte_index(cpu_req.addr, b)] = cpu_req.wdata[b*8 +: 8];
						end
					end
				end
			end else begin
				expected = expected_read(cpu_req.addr);
				if (cpu_rdata !== expected) begin
					$display("** Error: cpu_rdata = %h, expected %h at address %h",
						cpu_rdata, expected, cpu_req.addr);
					errors++;
				end
			end
		end
		// the display write is still outstanding when the strobe comes
		if (resetn && display_strobe) begin
			strobes++;
			if (!(cpu_valid && cpu_req.addr == display_addr && |cpu_req.wstrb)) begin
				$display("display_strobe pulsed with no display write outstanding");
				errors++;
			end else if (display_value !== cpu_req.wdata) begin
				$display("** Error: display_value = %h, expected %h",
					display_value, cpu_req.wdata);
				errors++;
			end
		end
	end

endmodule

// ==== tb/cached_memory_system_tb.sv ====
`timescale 1ns/10ps

module cached_memory_system_tb;
	import cache_pkg::*;

	logic clk;
	logic resetn;
	logic cpu_valid;
	mem_req_t cpu_req;
	logic cpu_ready;
	word_t cpu_rdata;
	word_t display_value;
	logic display_strobe;

	logic [31:0] lfsr_state;
	int timeout_count;
	int error_count;
	int monitor_errors;
	int strobe_count;

	cached_memory_system cached_memory_system_inst (
		.clk            (clk),
		.resetn         (resetn),
		.cpu_valid      (cpu_valid),
		.cpu_req        (cpu_req),
		.cpu_ready      (cpu_ready),
		.cpu_rdata      (cpu_rdata),
		.display_value  (display_value),
		.display_strobe (display_strobe)
	);

	cache_monitor cache_monitor_inst (
		.clk            (clk),
		.resetn         (resetn),
		.cpu_valid      (cpu_valid),
		.cpu_req        (cpu_req),
		.cpu_ready      (cpu_ready),
		.cpu_rdata      (cpu_rdata),
		.display_value  (display_value),
		.display_strobe (display_strobe),
		.error_count    (monitor_errors),
		.strobe_count   (strobe_count)
	);

	always #2 clk = ~clk;

	// galois lfsr stepped once per bit
	function automatic logic [31:0] random_bits(int n);
		logic [31:0] value;
		logic out_bit;
		value = '0;
		for (int i = 0; i < n; i++) begin
			out_bit = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	// word aligned and below 16 KB
	function automatic addr_t random_addr();
		addr_t value;
		value = random_bits(12) << 2;
		return value;
	endfunction

	task automatic do_request(input addr_t addr, input word_t wdata, input strb_t wstrb);
		int cycles;
		@(negedge clk);
		cpu_req.addr = addr;
		cpu_req.wdata = wdata;
		cpu_req.wstrb = wstrb;
		cpu_valid = 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!cpu_ready && cycles < 500) begin
			@(negedge clk);
			cycles++;
		end
		if (!cpu_ready) begin
			$display("timeout: no cpu_ready for the request to address %h", addr);
			timeout_count++;
		end
		// valid stays up through the ready cycle
		@(negedge clk);
		cpu_valid = 1'b0;
	endtask

	task automatic write_word(input addr_t addr, input word_t data, input strb_t strb);
		do_request(addr, data, strb);
	endtask

	task automatic read_word(input addr_t addr);
		do_request(addr, '0, '0);
	endtask

	initial begin
		addr_t a;
		word_t d;
		strb_t s;
		logic [31:0] op;
		int strobes_before;
		clk = 1'b0;
		resetn = 1'b0;
		cpu_valid = 1'b0;
		cpu_req = '0;
		lfsr_state = 32'hbadf;
		timeout_count = 0;
		error_count = 0;
		repeat (16) @(negedge clk);
		resetn = 1'b1;

		repeat (8) read_word(random_addr());

		write_word(32'h0000_0040, 32'h1234_5678, 4'hf);
		read_word(32'h0000_0040);
		write_word(32'h0000_0040, 32'haabb_ccdd, 4'b0101);
		read_word(32'h0000_0040);

		// same index with two tags
		for (int i = 0; i < 4; i++) begin
			write_word(32'h0000_0120, 32'h0120_0000 + i, 4'hf);
			write_word(32'h0000_0520, 32'h0520_0000 + i, 4'hf);
		end
		read_word(32'h0000_0120);
		read_word(32'h0000_0520);

		write_word(32'h0000_0200, 32'h0bad_0000, 4'hf);
		write_word(32'h0000_0204, 32'h0bad_0004, 4'hf);
		read_word(32'h0000_0600);
		read_word(32'h0000_0200);
		read_word(32'h0000_0204);

		strobes_before = strobe_count;
		write_word(display_addr, 32'hcafe_f00d, 4'hf);
		if (strobe_count != strobes_before + 1) begin
			$display("display_strobe did not pulse exactly once for the display write");
			error_count++;
		end
		read_word(display_addr);

		repeat (400) begin
			a = random_addr();
			op = random_bits(1);
			if (op[0]) begin
				s = strb_t'(random_bits(4));
				if (s == '0) begin
					s = '1;
				end
				d = random_bits(32);
				write_word(a, d, s);
			end else begin
				read_word(a);
			end
		end

		@(negedge clk);
		error_count = error_count + monitor_errors +
			cached_memory_system_inst.cache_controller_inst.cache_checker_inst.fail_count;
		$display("errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== project.f ====
hdl/cache_pkg.sv
hdl/cache_array.sv
hdl/cache_controller.sv
hdl/backing_memory.sv
hdl/cached_memory_system.sv
tb/cache_checker.sv
tb/cache_monitor.sv
tb/cached_memory_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module cached_memory_system_tb -o sim_cache
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
